/* logic/video_macros.svh */
// video timing constants
// raster geometry of the small test display, pattern pipe depth
// and the lead of the early enable over display enable
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// ------------------------------
// horizontal, in pixel clocks
// ------------------------------
// visible pixels per line
`define VID_HDISPLAY 16
`define VID_HFRONT 2
`define VID_HSYNC 3
`define VID_HBACK 3
// full line incl. blanking, 24 clocks
`define VID_HTOTAL (`VID_HDISPLAY + `VID_HFRONT + `VID_HSYNC + `VID_HBACK)

// ------------------------------
// vertical, in lines
// ------------------------------
`define VID_VDISPLAY 8
`define VID_VBOTTOM 1
`define VID_VSYNC 2
`define VID_VTOP 1
// full frame, 12 lines
`define VID_VTOTAL (`VID_VDISPLAY + `VID_VBOTTOM + `VID_VSYNC + `VID_VTOP)

// ------------------------------
// pattern pipeline
// ------------------------------
`define VID_PIPE 3
// early enable leads de by exactly the pipe depth
`define VID_LEAD `VID_PIPE
// raster coordinate width
`define VID_POSW 8

`endif

/* logic/videoTimingPkg.sv */
// raster timing types
// coordinates of the pixel/line counters and the sync state word
// that travels through the output registers

`include "video_macros.svh"

package videoTimingPkg;

    // raster coordinates
    typedef logic [`VID_POSW-1:0] hPos_t;   // pixel within line
    typedef logic [`VID_POSW-1:0] vPos_t;   // line within frame

    // ------------------------------
    // sync state, one small word
    // ------------------------------
    typedef struct packed {
        logic hsync;    // active high
        logic vsync;    // active high
        logic de;       // visible area
        logic fe;       // one clock per frame
    } syncState_t;

    // all flags low, used on reset
    localparam syncState_t SYNC_IDLE = '{
        hsync: 1'b0,
        vsync: 1'b0,
        de:    1'b0,
        fe:    1'b0
    };

endpackage

/* logic/videoPixelPkg.sv */
// pixel types for the pattern path
// RGB565 word, pattern mode, colour bar table and grey mapping

package videoPixelPkg;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;  // green gets the extra bit
        logic [4:0] b;
    } rgb565_t;

    typedef enum logic [1:0] {
        SOLID    = 2'd0,    // latched colour over the whole area
        BARS     = 2'd1,    // eight vertical bars
        CHECKER  = 2'd2,    // 2x2 black/white squares
        GRADIENT = 2'd3     // grey ramp along x + y
    } patMode_t;

    // classic bar order, white first and black last
    localparam rgb565_t barColor [0:7] = '{
        '{r: 5'h1f, g: 6'h3f, b: 5'h1f},   // white
        '{r: 5'h1f, g: 6'h3f, b: 5'h00},   // yellow
        '{r: 5'h00, g: 6'h3f, b: 5'h1f},   // cyan
        '{r: 5'h00, g: 6'h3f, b: 5'h00},   // green
        '{r: 5'h1f, g: 6'h00, b: 5'h1f},   // magenta
        '{r: 5'h1f, g: 6'h00, b: 5'h00},   // red
        '{r: 5'h00, g: 6'h00, b: 5'h1f},   // blue
        '{r: 5'h00, g: 6'h00, b: 5'h00}    // black
    };

    // 5 bit grey level to rgb565, green lsb copies the level msb
    function automatic rgb565_t greyOf(input logic [4:0] lvl);
        rgb565_t px;
        px.r = lvl;
        px.g = {lvl, lvl[4]};
        px.b = lvl;
        return px;
    endfunction

endpackage

/* logic/videoTimingIf.sv */
// timing bundle of the sync generator
// registered sync/enable flags plus the early enable and the
// leading coordinates for the pattern pipeline
`timescale 1ns/1ps

interface videoTimingIf;

    logic                  hsync;   // horizontal sync
    logic                  vsync;   // vertical sync
    logic                  de;      // display enable
    logic                  fde;     // early de, VID_LEAD clocks ahead
    logic                  fe;      // frame end strobe
    videoTimingPkg::hPos_t fx;      // leading x, valid with fde
    videoTimingPkg::vPos_t fy;      // leading y

    // ------------------------------
    // views
    // ------------------------------
    // sync generator drives everything
    modport gen (output hsync, vsync, de, fde, fe, fx, fy);

    // pattern pipe only needs the leading side and fe
    modport pat (input fde, fx, fy, fe);

    // output stage, main timing only
    modport out (input hsync, vsync, de, fe);

endinterface

/* logic/hvsyncGen.sv */
// hsync/vsync generator
// main pixel/line counters give registered sync, de and fe; a second
// counter pair runs VID_LEAD clocks ahead and gives the early enable
`timescale 1ns/1ps
`include "video_macros.svh"

module hvsyncGen
(
    input  logic      iCLK,
    input  logic      iRST,
    videoTimingIf.gen tim
);

    // thresholds, typed so compares stay at coordinate width
    localparam videoTimingPkg::hPos_t hDisp = videoTimingPkg::hPos_t'(`VID_HDISPLAY);
    localparam videoTimingPkg::hPos_t hSyncStart =
        videoTimingPkg::hPos_t'(`VID_HDISPLAY + `VID_HFRONT);
    localparam videoTimingPkg::hPos_t hSyncEnd =
        videoTimingPkg::hPos_t'(`VID_HDISPLAY + `VID_HFRONT + `VID_HSYNC - 1);
    localparam videoTimingPkg::hPos_t hMax = videoTimingPkg::hPos_t'(`VID_HTOTAL - 1);
    localparam videoTimingPkg::hPos_t hLead = videoTimingPkg::hPos_t'(`VID_LEAD);
    localparam videoTimingPkg::vPos_t vDisp = videoTimingPkg::vPos_t'(`VID_VDISPLAY);
    localparam videoTimingPkg::vPos_t vSyncStart =
        videoTimingPkg::vPos_t'(`VID_VDISPLAY + `VID_VBOTTOM);
    localparam videoTimingPkg::vPos_t vSyncEnd =
        videoTimingPkg::vPos_t'(`VID_VDISPLAY + `VID_VBOTTOM + `VID_VSYNC - 1);
    localparam videoTimingPkg::vPos_t vMax = videoTimingPkg::vPos_t'(`VID_VTOTAL - 1);

    videoTimingPkg::hPos_t      hPos;       // main pixel counter
    videoTimingPkg::vPos_t      vPos;       // main line counter
    videoTimingPkg::hPos_t      fHpos;      // leading pixel counter
    videoTimingPkg::vPos_t      fVpos;      // leading line counter
    logic                       lineEnd;
    logic                       frameEnd;
    logic                       fLineEnd;
    logic                       fFrameEnd;
    logic                       lock;       // set after first fe
    logic                       fdeNext;
    logic                       fdeReg;
    videoTimingPkg::hPos_t      fxReg;
    videoTimingPkg::vPos_t      fyReg;
    videoTimingPkg::syncState_t syncNext;
    videoTimingPkg::syncState_t syncReg;

    // ------------------------------
    // main raster
    // ------------------------------
    assign lineEnd  = (hPos == hMax);
    assign frameEnd = (vPos == vMax);

    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            hPos <= '0;
            vPos <= '0;
        end
        else
        begin
            hPos <= lineEnd ? '0 : hPos + 1'b1;
            if (lineEnd)
                vPos <= frameEnd ? '0 : vPos + 1'b1;  // line steps at end of line
        end
    end

    always_comb
    begin
        syncNext.hsync = (hPos >= hSyncStart) && (hPos <= hSyncEnd);
        syncNext.vsync = (vPos >= vSyncStart) && (vPos <= vSyncEnd);
        syncNext.de    = (hPos < hDisp) && (vPos < vDisp);
        syncNext.fe    = (hPos == hDisp) && (vPos == vDisp);  // first blank after last line
    end

    always_ff @(posedge iCLK)
    begin
        if (iRST)
            syncReg <= videoTimingPkg::SYNC_IDLE;
        else
            syncReg <= syncNext;                // one clock behind the counters
    end

    // ------------------------------
    // leading raster
    // ------------------------------
    assign fLineEnd  = (fHpos == hMax);
    assign fFrameEnd = (fVpos == vMax);

    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            fHpos <= hLead;                     // VID_LEAD positions ahead
            fVpos <= '0;
        end
        else
        begin
            fHpos <= fLineEnd ? '0 : fHpos + 1'b1;
            if (fLineEnd)
                fVpos <= fFrameEnd ? '0 : fVpos + 1'b1;
        end
    end

    // no early enable in the partial frame after reset
    always_ff @(posedge iCLK)
    begin
        if (iRST)
            lock <= 1'b0;
        else if (syncNext.fe)
            lock <= 1'b1;
    end

    assign fdeNext = lock && (fHpos < hDisp) && (fVpos < vDisp);

    always_ff @(posedge iCLK)
    begin
        if (iRST)
            fdeReg <= 1'b0;
        else
            fdeReg <= fdeNext;
    end

    // coordinates registered alongside fde
    always_ff @(posedge iCLK)
    begin
        fxReg <= fHpos;
        fyReg <= fVpos;
    end

    assign tim.hsync = syncReg.hsync;
    assign tim.vsync = syncReg.vsync;
    assign tim.de    = syncReg.de;
    assign tim.fe    = syncReg.fe;
    assign tim.fde   = fdeReg;
    assign tim.fx    = fxReg;
    assign tim.fy    = fyReg;

endmodule

/* logic/patternGen.sv */
// test pattern generator
// three register stages started by the early enable, so each pixel
// comes out in the clock where the main de covers it
`timescale 1ns/1ps
`include "video_macros.svh"

module patternGen
(
    input  logic                    iCLK,
    input  logic                    iRST,
    input  videoPixelPkg::patMode_t iMode,
    input  videoPixelPkg::rgb565_t  iColor,
    videoTimingIf.pat               tim,
    output videoPixelPkg::rgb565_t  pixel
);

    videoPixelPkg::patMode_t modeLat;   // frame-stable mode
    videoPixelPkg::rgb565_t  colorLat;  // frame-stable solid colour

    logic                    s1Valid;
    videoTimingPkg::hPos_t   s1X;
    videoTimingPkg::vPos_t   s1Y;

    logic [`VID_POSW+2:0]    xTimes8;
    logic [2:0]              barNext;
    logic                    s2Valid;
    logic [2:0]              s2Bar;     // bar index 0..7
    logic                    s2Check;   // checker square colour
    logic [`VID_POSW:0]      s2Sum;     // x + y for the ramp

    logic [4:0]              greyLvl;
    videoPixelPkg::rgb565_t  pixNext;

    // mode/colour only move at frame end, no tearing
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            modeLat  <= videoPixelPkg::SOLID;
            colorLat <= '0;
        end
        else if (tim.fe)
        begin
            modeLat  <= iMode;
            colorLat <= iColor;
        end
    end

    // ------------------------------
    // stage 1: coordinates + valid
    // ------------------------------
    always_ff @(posedge iCLK)
    begin
        if (iRST || !tim.fde)
        begin
            s1Valid <= 1'b0;
            s1X     <= '0;
            s1Y     <= '0;
        end
        else
        begin
            s1Valid <= 1'b1;
            s1X     <= tim.fx;
            s1Y     <= tim.fy;
        end
    end

    // ------------------------------
    // stage 2: bar, checker, sum
    // ------------------------------
    assign xTimes8 = {s1X, 3'b000};
    assign barNext = 3'(xTimes8 / `VID_HDISPLAY);   // fx * 8 / width

    always_ff @(posedge iCLK)
    begin
        if (iRST || !s1Valid)
        begin
            s2Valid <= 1'b0;
            s2Bar   <= '0;
            s2Check <= 1'b0;
            s2Sum   <= '0;
        end
        else
        begin
            s2Valid <= 1'b1;
            s2Bar   <= barNext;
            s2Check <= s1X[1] ^ s1Y[1];             // 2x2 squares
            s2Sum   <= {1'b0, s1X} + {1'b0, s1Y};
        end
    end

    // ------------------------------
    // stage 3: select by mode
    // ------------------------------
    // ramp saturates at full white
    assign greyLvl = (s2Sum[`VID_POSW:5] != '0) ? 5'h1f : s2Sum[4:0];

    always_comb
    begin
        unique case (modeLat)
            videoPixelPkg::SOLID:    pixNext = colorLat;
            videoPixelPkg::BARS:     pixNext = videoPixelPkg::barColor[s2Bar];
            videoPixelPkg::CHECKER:  pixNext = s2Check ? videoPixelPkg::barColor[0]
                                                       : videoPixelPkg::barColor[7];
            videoPixelPkg::GRADIENT: pixNext = videoPixelPkg::greyOf(greyLvl);
        endcase
    end

    always_ff @(posedge iCLK)
    begin
        if (iRST || !s2Valid)
            pixel <= '0;                            // idle slots stay black
        else
            pixel <= pixNext;
    end

endmodule

/* logic/videoOut.sv */
// video output stage
// one register for sync flags and pixel together, blanking forces
// the pixel to zero
`timescale 1ns/1ps

module videoOut
(
    input  logic                   iCLK,
    input  logic                   iRST,
    videoTimingIf.out              tim,
    input  videoPixelPkg::rgb565_t pixel,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   de,
    output logic                   fe,
    output videoPixelPkg::rgb565_t rgb
);

    videoTimingPkg::syncState_t syncReg;    // timing word, one clock late
    videoPixelPkg::rgb565_t     pixReg;

    // ------------------------------
    // output register
    // ------------------------------
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            syncReg <= videoTimingPkg::SYNC_IDLE;
            pixReg  <= '0;
        end
        else
        begin
            syncReg <= '{
                hsync: tim.hsync,
                vsync: tim.vsync,
                de:    tim.de,
                fe:    tim.fe
            };
            pixReg  <= tim.de ? pixel : '0;     // black outside the visible area
        end
    end

    assign hsync = syncReg.hsync;
    assign vsync = syncReg.vsync;
    assign de    = syncReg.de;
    assign fe    = syncReg.fe;
    assign rgb   = pixReg;

endmodule

/* logic/videoSubsystem.sv */
// video timing and test pattern top level
// sync generator, pattern pipeline and output register, plain
// ports outside and the timing interface inside
`timescale 1ns/1ps

module videoSubsystem
(
    input  logic        iCLK,
    input  logic        iRST,
    input  logic [1:0]  iMode,      // patMode_t encoding
    input  logic [15:0] iColor,     // rgb565 solid colour
    output logic        oHsync,
    output logic        oVsync,
    output logic        oDe,
    output logic        oFe,
    output logic [15:0] oPixel
);

    videoTimingIf tim ();

    videoPixelPkg::patMode_t modeSel;
    videoPixelPkg::rgb565_t  colorSel;
    videoPixelPkg::rgb565_t  patPixel;  // pipe -> output stage
    videoPixelPkg::rgb565_t  outPixel;

    assign modeSel  = videoPixelPkg::patMode_t'(iMode);
    assign colorSel = iColor;
    assign oPixel   = outPixel;

    // ------------------------------
    // blocks
    // ------------------------------
    hvsyncGen uHvsync
    (
        .iCLK   (iCLK),
        .iRST   (iRST),
        .tim    (tim.gen)
    );

    patternGen uPattern
    (
        .iCLK   (iCLK),
        .iRST   (iRST),
        .iMode  (modeSel),
        .iColor (colorSel),
        .tim    (tim.pat),
        .pixel  (patPixel)
    );

    videoOut uOut
    (
        .iCLK   (iCLK),
        .iRST   (iRST),
        .tim    (tim.out),
        .pixel  (patPixel),
        .hsync  (oHsync),
        .vsync  (oVsync),
        .de     (oDe),
        .fe     (oFe),
        .rgb    (outPixel)
    );

endmodule

/* tests/video_asserts.sv */
// concurrent checks on the video output pins
// sync, enable and blanking relations, bound into the top level
`timescale 1ns/1ps

module videoAsserts
(
    input logic        iCLK,
    input logic        iRST,
    input logic        oHsync,
    input logic        oDe,
    input logic        oFe,
    input logic [15:0] oPixel
);

    // frame end sits in blanking
    feInBlank: assert property (@(posedge iCLK) disable iff (iRST) oFe |-> !oDe)
        else $error("oFe high while oDe is high");

    // blanked pixels are black
    pixelBlank: assert property (@(posedge iCLK) disable iff (iRST) !oDe |-> oPixel == 16'h0000)
        else $error("oPixel not zero outside oDe");

    // sync pulse never overlaps the visible area
    syncNotVisible: assert property (@(posedge iCLK) disable iff (iRST) !(oHsync && oDe))
        else $error("oHsync and oDe high together");

    // single clock strobe
    feSingle: assert property (@(posedge iCLK) disable iff (iRST) oFe |=> !oFe)
        else $error("oFe high on two consecutive clocks");

endmodule

bind videoSubsystem videoAsserts uAsserts
(
    .iCLK   (iCLK),
    .iRST   (iRST),
    .oHsync (oHsync),
    .oDe    (oDe),
    .oFe    (oFe),
    .oPixel (oPixel)
);

/* tests/tb_videoSubsystem.sv */
// testbench for the video timing and test pattern subsystem
// random mode/colour change once per frame, reference raster model
// checked against every output on every clock
`timescale 1ns/1ps
`include "video_macros.svh"

module tb_videoSubsystem;

    localparam int clkHalf    = 2;                      // 4 ns period
    localparam int rstCycles  = 16;
    localparam int hTotal     = `VID_HTOTAL;
    localparam int frameClks  = `VID_HTOTAL * `VID_VTOTAL;
    localparam int runFrames  = 6;
    localparam int hsStart    = `VID_HDISPLAY + `VID_HFRONT;
    localparam int hsEnd      = hsStart + `VID_HSYNC;
    localparam int vsStart    = `VID_VDISPLAY + `VID_VBOTTOM;
    localparam int vsEnd      = vsStart + `VID_VSYNC;
    localparam int firstFe    = (`VID_HDISPLAY + 1) + `VID_VDISPLAY * hTotal + 1;
    // model raster origin, placed so its first fe lands on firstFe
    localparam int modelStart = firstFe - `VID_HDISPLAY - `VID_VDISPLAY * hTotal;
    localparam int watchdogNs = 8 * frameClks * 2 * clkHalf;

    logic        iCLK;
    logic        iRST;
    logic [1:0]  iMode;
    logic [15:0] iColor;
    logic        oHsync;
    logic        oVsync;
    logic        oDe;
    logic        oFe;
    logic [15:0] oPixel;

    int          seed;
    int          edgeCnt;           // clocks since reset release
    int          hCnt;              // model pixel counter
    int          vCnt;              // model line counter
    int          frameCnt;
    int          posInFrame;
    int          changeAt;          // clock of this frame's input change
    logic [1:0]  prevMode;          // inputs as the DUT sees them next edge
    logic [15:0] prevColor;
    logic [1:0]  modeLat;           // model copy of the frame-end latch
    logic [15:0] colorLat;
    logic        frameValid;        // a frame end has been seen
    logic [3:0]  modesUsed;
    logic [3:0]  modesChecked;

    videoSubsystem uut
    (
        .iCLK   (iCLK),
        .iRST   (iRST),
        .iMode  (iMode),
        .iColor (iColor),
        .oHsync (oHsync),
        .oVsync (oVsync),
        .oDe    (oDe),
        .oFe    (oFe),
        .oPixel (oPixel)
    );

    always #clkHalf iCLK = ~iCLK;

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic abortRun;
        $display("Result: FAILED");
        $fatal(1, "testbench stopped after a failure");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            abortRun();
        end
    endtask

    task automatic randBelow(input int limit, output int value);
        logic [31:0] rnd;
        rnd = $random(seed);
        value = int'(rnd % 32'(limit));
    endtask

    // expected visible pixel for one raster position
    function automatic logic [15:0] patternPixel(input logic [1:0] mode,
                                                 input logic [15:0] color,
                                                 input int x, input int y);
        logic [2:0]  bar;
        logic [4:0]  lvl;
        logic [15:0] px;
        bar = 3'(x * 8 / `VID_HDISPLAY);            // eight equal bars
        lvl = (x + y > 31) ? 5'd31 : 5'(x + y);     // ramp clamps at white
        case (mode)
            videoPixelPkg::SOLID:   px = color;
            videoPixelPkg::BARS:    px = videoPixelPkg::barColor[bar];
            videoPixelPkg::CHECKER: px = ((((x >> 1) ^ (y >> 1)) & 1) != 0) ? 16'hffff : 16'h0000;
            default:                px = {lvl, lvl, lvl[4], lvl};   // grey, g lsb from msb
        endcase
        return px;
    endfunction

    // new mode and colour, steered to an unused mode until all four ran
    task automatic pickInputs;
        logic [31:0] rnd;
        logic [1:0]  mode;
        rnd = $random(seed);
        mode = rnd[1:0];
        while (modesUsed != 4'hf && modesUsed[mode])
            mode = mode + 2'd1;
        modesUsed[mode] = 1'b1;
        iMode  <= mode;
        iColor <= rnd[31:16];
    endtask

    // ------------------------------
    // per clock model and compare
    // ------------------------------
    task automatic checkCycle;
        logic        hs;
        logic        vs;
        logic        de;
        logic        fe;
        logic [15:0] px;
        hs = 1'b0;
        vs = 1'b0;
        de = 1'b0;
        fe = 1'b0;
        px = 16'h0000;                              // blank and first frame
        if (edgeCnt >= modelStart)                  // raster reaches the pins from here
        begin
            hs = (hCnt >= hsStart) && (hCnt < hsEnd);
            vs = (vCnt >= vsStart) && (vCnt < vsEnd);
            de = (hCnt < `VID_HDISPLAY) && (vCnt < `VID_VDISPLAY);
            fe = (hCnt == `VID_HDISPLAY) && (vCnt == `VID_VDISPLAY);
            if (de && frameValid)
            begin
                px = patternPixel(modeLat, colorLat, hCnt, vCnt);
                modesChecked[modeLat] = 1'b1;
            end
        end
        checkValue("oHsync", 32'(oHsync), 32'(hs));
        checkValue("oVsync", 32'(oVsync), 32'(vs));
        checkValue("oDe", 32'(oDe), 32'(de));
        checkValue("oFe", 32'(oFe), 32'(fe));
        checkValue("oPixel", 32'(oPixel), 32'(px));
        if (fe)
        begin
            // mid-frame changes only count from here on
            modeLat    = prevMode;
            colorLat   = prevColor;
            frameValid = 1'b1;
            frameCnt   = frameCnt + 1;
            posInFrame = 0;
            randBelow(frameClks - 1, changeAt);
        end
        if (edgeCnt >= modelStart)
        begin
            if (hCnt == hTotal - 1)
            begin
                hCnt = 0;
                vCnt = (vCnt == `VID_VTOTAL - 1) ? 0 : vCnt + 1;
            end
            else
                hCnt = hCnt + 1;
        end
        prevMode  = iMode;
        prevColor = iColor;
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial
    begin
        iCLK         = 1'b0;
        iRST         = 1'b1;
        iMode        = 2'd0;
        iColor       = 16'h0000;
        seed         = 32'h296b;
        edgeCnt      = 0;
        hCnt         = 0;
        vCnt         = 0;
        frameCnt     = 0;
        posInFrame   = 0;
        prevMode     = 2'd0;
        prevColor    = 16'h0000;
        modeLat      = 2'd0;
        colorLat     = 16'h0000;
        frameValid   = 1'b0;
        modesUsed    = 4'h0;
        modesChecked = 4'h0;
        randBelow(firstFe - 2, changeAt);           // lands before the first fe
        repeat (rstCycles - 1)
        begin
            @(posedge iCLK);
            @(negedge iCLK);
            checkCycle();                           // outputs idle in reset
        end
        @(posedge iCLK);
        iRST <= 1'b0;
        while (frameCnt < runFrames)
        begin
            @(posedge iCLK);
            edgeCnt = edgeCnt + 1;
            if (posInFrame == changeAt)
                pickInputs();
            posInFrame = posInFrame + 1;
            @(negedge iCLK);                        // outputs settled here
            checkCycle();
        end
        if (modesChecked == 4'hf)
        begin
            $display("Result: PASSED");
            $finish;
        end
        else
        begin
            $display("not every pattern mode was shown in a checked frame");
            abortRun();
        end
    end

    // watchdog, 8 frames of clocks
    initial
    begin
        #(watchdogNs);
        $display("watchdog expired after %0d ns without reaching the end of the test",
                 watchdogNs);
        abortRun();
    end

endmodule

/* build.f */
+incdir+logic
logic/videoTimingPkg.sv
logic/videoPixelPkg.sv
logic/videoTimingIf.sv
logic/hvsyncGen.sv
logic/patternGen.sv
logic/videoOut.sv
logic/videoSubsystem.sv
tests/video_asserts.sv
tests/tb_videoSubsystem.sv

/* run.sh */
#!/bin/sh
# compile with Verilator and run, exit status carries pass or fail
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module tb_videoSubsystem -f build.f -o simv &&
./obj_dir/simv || exit 1
